/* src/soc_pkg.sv */
package soc_pkg;

	////////////////////////////////////////////////////////////
	// Bus word and command types
	////////////////////////////////////////////////////////////

	localparam int SOC_DATA_W = 32;

	// Word address, split into target region and word offset
	typedef struct packed {
		logic [3:0]  region;
		logic [11:0] offset;
	} soc_adr_t;

	typedef struct packed {
		logic                  we;
		soc_adr_t              adr;
		logic [SOC_DATA_W-1:0] wdat;
	} soc_cmd_t;

	typedef struct packed {
		logic [SOC_DATA_W-1:0] rdat;
		logic                  err;
	} soc_rsp_t;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////

	localparam logic [3:0] SOC_REGION_ROM   = 4'hF;
	localparam logic [3:0] SOC_REGION_GPIO0 = 4'h9;
	localparam logic [3:0] SOC_REGION_GPIO1 = 4'hA;

	// GPIO register offsets
	localparam logic [11:0] SOC_GPIO_DATA = 12'd0;
	localparam logic [11:0] SOC_GPIO_DIR  = 12'd1;
	localparam logic [11:0] SOC_GPIO_PEND = 12'd2;

	// Boot ROM contents
	localparam int                    SOC_ROM_DEPTH     = 16;
	localparam int                    SOC_ROM_AW        = $clog2(SOC_ROM_DEPTH);
	localparam logic [SOC_DATA_W-1:0] SOC_ROM_BASE_WORD = 32'hB0070000;

	// Returned on reads that hit nothing
	localparam logic [SOC_DATA_W-1:0] SOC_DEAD_DATA = 32'hDEADDEAD;

	localparam int SOC_FIFO_DEPTH = 4;

	// Interrupt vector
	localparam int SOC_IRQ_W     = 2;
	localparam int SOC_IRQ_GPIO0 = 0;
	localparam int SOC_IRQ_GPIO1 = 1;

	// Word k of the boot ROM
	function automatic logic [SOC_DATA_W-1:0] soc_rom_word(input int unsigned k);
		return SOC_ROM_BASE_WORD + k;
	endfunction

endpackage

/* src/gpio_port.sv */
module gpio_port #(
	parameter int WIDTH = 8
) (
	input  logic                           wb_clk_i,
	input  logic                           arst_n_i,
	input  logic                           sel_i,
	input  logic                           we_i,
	input  logic [11:0]                    offset_i,
	input  logic [soc_pkg::SOC_DATA_W-1:0] wdat_i,
	output logic [soc_pkg::SOC_DATA_W-1:0] rdat_o,
	input  logic [WIDTH-1:0]               pin_i,
	output logic [WIDTH-1:0]               pin_o,
	output logic [WIDTH-1:0]               pin_oe_o,
	output logic                           irq_o
);

	logic [WIDTH-1:0] dout_q;
	logic [WIDTH-1:0] dir_q;
	logic [WIDTH-1:0] pend_q;
	logic [WIDTH-1:0] sync1_q;
	logic [WIDTH-1:0] sync2_q;
	logic [WIDTH-1:0] prev_q;
	logic [WIDTH-1:0] pin_chg;
	logic [WIDTH-1:0] pend_clr;
	logic             wr;

	////////////////////////////////////////////////////////////
	// Input synchronizer and change detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= pin_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	// Output pins never raise an interrupt
	assign pin_chg = (sync2_q ^ prev_q) & ~dir_q;

	////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////

	assign wr       = sel_i && we_i;
	assign pend_clr = (wr && offset_i == soc_pkg::SOC_GPIO_PEND) ? wdat_i[WIDTH-1:0] : '0;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dout_q <= '0;
			dir_q  <= '0;
			pend_q <= '0;
		end else begin
			if (wr && offset_i == soc_pkg::SOC_GPIO_DATA) begin
				dout_q <= wdat_i[WIDTH-1:0];
			end
			if (wr && offset_i == soc_pkg::SOC_GPIO_DIR) begin
				dir_q <= wdat_i[WIDTH-1:0];
			end
			// A new change wins over a clear in the same cycle
			pend_q <= (pend_q & ~pend_clr) | pin_chg;
		end
	end

	assign pin_o    = dout_q;
	assign pin_oe_o = dir_q;
	assign irq_o    = |pend_q;

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		rdat_o = '0;
		case (offset_i)
			soc_pkg::SOC_GPIO_DATA: begin
				// Driven bits from the register, the rest from the pads
				rdat_o[WIDTH-1:0] = (dout_q & dir_q) | (sync2_q & ~dir_q);
			end
			soc_pkg::SOC_GPIO_DIR: begin
				rdat_o[WIDTH-1:0] = dir_q;
			end
			soc_pkg::SOC_GPIO_PEND: begin
				rdat_o[WIDTH-1:0] = pend_q;
			end
			default: begin
				rdat_o = '0;
			end
		endcase
	end

endmodule

/* src/boot_rom.sv */
module boot_rom (
	input  logic                           wb_clk_i,
	input  logic                           arst_n_i,
	input  logic                           sel_i,
	input  logic [soc_pkg::SOC_ROM_AW-1:0] offset_i,
	output logic [soc_pkg::SOC_DATA_W-1:0] rdat_o
);

	logic [soc_pkg::SOC_DATA_W-1:0] rom_tbl [soc_pkg::SOC_ROM_DEPTH];

	////////////////////////////////////////////////////////////
	// Boot word table
	////////////////////////////////////////////////////////////

	// Each word is the base word plus its index
	for (genvar k = 0; k < soc_pkg::SOC_ROM_DEPTH; k++) begin : g_word
		assign rom_tbl[k] = soc_pkg::soc_rom_word(k);
	end

	// Registered read, data is ready the cycle after select
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdat_o <= '0;
		end else if (sel_i) begin
			rdat_o <= rom_tbl[offset_i];
		end
	end

endmodule

/* src/cmd_fifo.sv */
module cmd_fifo #(
	parameter int DEPTH = soc_pkg::SOC_FIFO_DEPTH
) (
	input  logic              wb_clk_i,
	input  logic              arst_n_i,
	input  logic              push_valid_i,
	output logic              push_ready_o,
	input  soc_pkg::soc_cmd_t push_cmd_i,
	output logic              pop_valid_o,
	input  logic              pop_ready_i,
	output soc_pkg::soc_cmd_t pop_cmd_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	soc_pkg::soc_cmd_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             push;
	logic             pop;

	assign push_ready_o = (count_q != CNT_W'(DEPTH));
	assign pop_valid_o  = (count_q != '0);
	assign push         = push_valid_i && push_ready_o;
	assign pop          = pop_valid_o && pop_ready_i;
	assign pop_cmd_o    = mem[rd_ptr_q];

	// Storage
	always_ff @(posedge wb_clk_i) begin
		if (push) begin
			mem[wr_ptr_q] <= push_cmd_i;
		end
	end

	// Pointers wrap at DEPTH, count tracks occupancy
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		count_q <= CNT_W'(DEPTH))
		else $error("queue count above depth");

endmodule

/* src/bus_decoder.sv */
module bus_decoder (
	input  logic                           wb_clk_i,
	input  logic                           arst_n_i,
	input  logic                           pop_valid_i,
	output logic                           pop_ready_o,
	input  soc_pkg::soc_cmd_t              pop_cmd_i,
	output logic                           rsp_valid_o,
	output soc_pkg::soc_rsp_t              rsp_o,
	output logic                           gpio0_sel_o,
	output logic                           gpio1_sel_o,
	output logic                           rom_sel_o,
	output logic                           tgt_we_o,
	output logic [11:0]                    tgt_offset_o,
	output logic [soc_pkg::SOC_DATA_W-1:0] tgt_wdat_o,
	input  logic [soc_pkg::SOC_DATA_W-1:0] gpio0_rdat_i,
	input  logic [soc_pkg::SOC_DATA_W-1:0] gpio1_rdat_i,
	input  logic [soc_pkg::SOC_DATA_W-1:0] rom_rdat_i
);

	typedef enum logic [1:0] {
		RD_GPIO,
		RD_ROM,
		RD_ERR
	} rd_src_e;

	logic                           take;
	logic                           take_rd;
	logic                           hit_gpio0;
	logic                           hit_gpio1;
	logic                           hit_rom;
	logic                           rom_in_range;
	logic                           rd_pend_q;
	rd_src_e                        rd_src_q;
	logic [soc_pkg::SOC_DATA_W-1:0] gpio_dat_q;

	////////////////////////////////////////////////////////////
	// Command accept and region decode
	////////////////////////////////////////////////////////////

	// No new command in the cycle a read response is due
	assign pop_ready_o = !rd_pend_q;
	assign take        = pop_valid_i && pop_ready_o;
	assign take_rd     = take && !pop_cmd_i.we;

	assign hit_gpio0    = (pop_cmd_i.adr.region == soc_pkg::SOC_REGION_GPIO0);
	assign hit_gpio1    = (pop_cmd_i.adr.region == soc_pkg::SOC_REGION_GPIO1);
	assign hit_rom      = (pop_cmd_i.adr.region == soc_pkg::SOC_REGION_ROM);
	assign rom_in_range = (pop_cmd_i.adr.offset < soc_pkg::SOC_ROM_DEPTH);

	// ROM is only selected for reads, so ROM writes fall away
	assign gpio0_sel_o = take && hit_gpio0;
	assign gpio1_sel_o = take && hit_gpio1;
	assign rom_sel_o   = take_rd && hit_rom && rom_in_range;

	assign tgt_we_o     = pop_cmd_i.we;
	assign tgt_offset_o = pop_cmd_i.adr.offset;
	assign tgt_wdat_o   = pop_cmd_i.wdat;

	////////////////////////////////////////////////////////////
	// Read response
	////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_pend_q <= 1'b0;
			rd_src_q  <= RD_ERR;
		end else begin
			rd_pend_q <= take_rd;
			if (take_rd) begin
				if (hit_gpio0 || hit_gpio1) begin
					rd_src_q <= RD_GPIO;
				end else if (hit_rom && rom_in_range) begin
					rd_src_q <= RD_ROM;
				end else begin
					rd_src_q <= RD_ERR;
				end
			end
		end
	end

	// GPIO data is combinational, so catch it at pop time
	always_ff @(posedge wb_clk_i) begin
		if (take_rd) begin
			gpio_dat_q <= hit_gpio1 ? gpio1_rdat_i : gpio0_rdat_i;
		end
	end

	assign rsp_valid_o = rd_pend_q;

	always_comb begin
		case (rd_src_q)
			RD_GPIO: rsp_o = '{rdat: gpio_dat_q, err: 1'b0};
			RD_ROM:  rsp_o = '{rdat: rom_rdat_i, err: 1'b0};
			default: rsp_o = '{rdat: soc_pkg::SOC_DEAD_DATA, err: 1'b1};
		endcase
	end

	a_one_sel: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		$onehot0({gpio0_sel_o, gpio1_sel_o, rom_sel_o}))
		else $error("more than one target selected");

endmodule

/* src/dbg_bridge.sv */
module dbg_bridge (
	input  logic              wb_clk_i,
	input  logic              arst_n_i,
	input  logic              host_req_i,
	input  soc_pkg::soc_cmd_t host_cmd_i,
	output logic              host_ack_o,
	output soc_pkg::soc_rsp_t host_rsp_o,
	output logic              push_valid_o,
	input  logic              push_ready_i,
	output soc_pkg::soc_cmd_t push_cmd_o,
	input  logic              rsp_valid_i,
	input  soc_pkg::soc_rsp_t rsp_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PUSH,
		ST_WAIT,
		ST_ACK
	} state_e;

	state_e            state_q;
	soc_pkg::soc_rsp_t rsp_q;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (host_req_i) begin
						state_q <= ST_PUSH;
					end
				end
				ST_PUSH: begin
					// Posted writes finish here, reads wait for data
					if (push_ready_i) begin
						state_q <= host_cmd_i.we ? ST_ACK : ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (rsp_valid_i) begin
						state_q <= ST_ACK;
					end
				end
				default: begin
					// Hold ack until the host lets go of req
					if (!host_req_i) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Host keeps the command stable while req is high
	assign push_valid_o = (state_q == ST_PUSH);
	assign push_cmd_o   = host_cmd_i;
	assign host_ack_o   = (state_q == ST_ACK);

	// Read data for the host, valid while ack is high
	always_ff @(posedge wb_clk_i) begin
		if (rsp_valid_i) begin
			rsp_q <= rsp_i;
		end
	end

	assign host_rsp_o = rsp_q;

	// Decoder only answers the read this bridge is waiting on
	a_rsp_in_wait: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		rsp_valid_i |-> state_q == ST_WAIT)
		else $error("read response outside the wait state");

endmodule

/* src/soc_top.sv */
module soc_top (
	input  logic                           wb_clk_i,
	input  logic                           arst_n_i,
	input  logic                           host_req_i,
	input  soc_pkg::soc_cmd_t              host_cmd_i,
	output logic                           host_ack_o,
	output soc_pkg::soc_rsp_t              host_rsp_o,
	input  logic [7:0]                     gpio0_i,
	output logic [7:0]                     gpio0_o,
	output logic [7:0]                     gpio0_oe_o,
	input  logic [3:0]                     gpio1_i,
	output logic [soc_pkg::SOC_IRQ_W-1:0]  irq_o
);

	////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////

	// Bridge to queue
	logic              push_valid;
	logic              push_ready;
	soc_pkg::soc_cmd_t push_cmd;

	// Queue to decoder
	logic              pop_valid;
	logic              pop_ready;
	soc_pkg::soc_cmd_t pop_cmd;

	// Read response back to the bridge
	logic              rsp_valid;
	soc_pkg::soc_rsp_t rsp;

	// Target side
	logic                            gpio0_sel;
	logic                            gpio1_sel;
	logic                            rom_sel;
	logic                            tgt_we;
	logic [11:0]                     tgt_offset;
	logic [soc_pkg::SOC_DATA_W-1:0]  tgt_wdat;
	logic [soc_pkg::SOC_DATA_W-1:0]  gpio0_rdat;
	logic [soc_pkg::SOC_DATA_W-1:0]  gpio1_rdat;
	logic [soc_pkg::SOC_DATA_W-1:0]  rom_rdat;

	dbg_bridge dbg_bridge0 (
		.wb_clk_i     (wb_clk_i),
		.arst_n_i     (arst_n_i),
		.host_req_i   (host_req_i),
		.host_cmd_i   (host_cmd_i),
		.host_ack_o   (host_ack_o),
		.host_rsp_o   (host_rsp_o),
		.push_valid_o (push_valid),
		.push_ready_i (push_ready),
		.push_cmd_o   (push_cmd),
		.rsp_valid_i  (rsp_valid),
		.rsp_i        (rsp)
	);

	cmd_fifo cmd_fifo0 (
		.wb_clk_i     (wb_clk_i),
		.arst_n_i     (arst_n_i),
		.push_valid_i (push_valid),
		.push_ready_o (push_ready),
		.push_cmd_i   (push_cmd),
		.pop_valid_o  (pop_valid),
		.pop_ready_i  (pop_ready),
		.pop_cmd_o    (pop_cmd)
	);

	bus_decoder bus_decoder0 (
		.wb_clk_i     (wb_clk_i),
		.arst_n_i     (arst_n_i),
		.pop_valid_i  (pop_valid),
		.pop_ready_o  (pop_ready),
		.pop_cmd_i    (pop_cmd),
		.rsp_valid_o  (rsp_valid),
		.rsp_o        (rsp),
		.gpio0_sel_o  (gpio0_sel),
		.gpio1_sel_o  (gpio1_sel),
		.rom_sel_o    (rom_sel),
		.tgt_we_o     (tgt_we),
		.tgt_offset_o (tgt_offset),
		.tgt_wdat_o   (tgt_wdat),
		.gpio0_rdat_i (gpio0_rdat),
		.gpio1_rdat_i (gpio1_rdat),
		.rom_rdat_i   (rom_rdat)
	);

	gpio_port #(.WIDTH(8)) gpio0 (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.sel_i    (gpio0_sel),
		.we_i     (tgt_we),
		.offset_i (tgt_offset),
		.wdat_i   (tgt_wdat),
		.rdat_o   (gpio0_rdat),
		.pin_i    (gpio0_i),
		.pin_o    (gpio0_o),
		.pin_oe_o (gpio0_oe_o),
		.irq_o    (irq_o[soc_pkg::SOC_IRQ_GPIO0])
	);

	// Input-only port, pads out and direction unused
	gpio_port #(.WIDTH(4)) gpio1 (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.sel_i    (gpio1_sel),
		.we_i     (tgt_we),
		.offset_i (tgt_offset),
		.wdat_i   (tgt_wdat),
		.rdat_o   (gpio1_rdat),
		.pin_i    (gpio1_i),
		.pin_o    (),
		.pin_oe_o (),
		.irq_o    (irq_o[soc_pkg::SOC_IRQ_GPIO1])
	);

	boot_rom boot_rom0 (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.sel_i    (rom_sel),
		.offset_i (tgt_offset[soc_pkg::SOC_ROM_AW-1:0]),
		.rdat_o   (rom_rdat)
	);

endmodule

/* verif/soc_tb.sv */
module soc_tb;

	localparam int WAIT_LIMIT = 200;

	logic                          clk;
	logic                          arst_n;
	logic                          host_req;
	soc_pkg::soc_cmd_t             host_cmd;
	logic                          host_ack;
	soc_pkg::soc_rsp_t             host_rsp;
	logic [7:0]                    gpio0_in;
	logic [7:0]                    gpio0_out;
	logic [7:0]                    gpio0_oe;
	logic [3:0]                    gpio1_in;
	logic [soc_pkg::SOC_IRQ_W-1:0] irq;

	// Expected values and the flags that arm each check
	logic              rst_chk;
	logic              rd_chk;
	logic              pad_chk;
	logic              irq_chk;
	logic              exp_irq1;
	soc_pkg::soc_rsp_t exp_rsp;
	logic [7:0]        exp_oe;
	logic [7:0]        exp_dout;
	logic              hung;

	integer     seed;
	int         errors;
	int         err_mark;
	int         tests_run;
	int         tests_bad;
	logic [7:0] dir_val;
	logic [31:0] wdat;
	logic [3:0] pat;

	soc_top uut (
		.wb_clk_i   (clk),
		.arst_n_i   (arst_n),
		.host_req_i (host_req),
		.host_cmd_i (host_cmd),
		.host_ack_o (host_ack),
		.host_rsp_o (host_rsp),
		.gpio0_i    (gpio0_in),
		.gpio0_o    (gpio0_out),
		.gpio0_oe_o (gpio0_oe),
		.gpio1_i    (gpio1_in),
		.irq_o      (irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk)
		rst_chk |-> (host_ack == 1'b0 && gpio0_out == '0 && gpio0_oe == '0 && irq == '0))
		else begin
			$display("mismatch reset outputs: host_ack_o %h gpio0_o %h gpio0_oe_o %h irq_o %h",
				$sampled(host_ack), $sampled(gpio0_out), $sampled(gpio0_oe), $sampled(irq));
			errors++;
		end

	// Read data is compared once, as ack rises
	a_rsp_match: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(host_ack) && rd_chk) |-> host_rsp == exp_rsp)
		else begin
			$display("mismatch host_rsp_o: got %h expected %h",
				$sampled(host_rsp), $sampled(exp_rsp));
			errors++;
		end

	a_oe_match: assert property (@(posedge clk) disable iff (!arst_n)
		pad_chk |-> gpio0_oe == exp_oe)
		else begin
			$display("mismatch gpio0_oe_o: got %h expected %h", $sampled(gpio0_oe), $sampled(exp_oe));
			errors++;
		end

	// Only the driven bits carry the data value
	a_dout_match: assert property (@(posedge clk) disable iff (!arst_n)
		pad_chk |-> (gpio0_out & exp_oe) == (exp_dout & exp_oe))
		else begin
			$display("mismatch gpio0_o: got %h expected %h under mask %h",
				$sampled(gpio0_out), $sampled(exp_dout), $sampled(exp_oe));
			errors++;
		end

	a_irq_match: assert property (@(posedge clk) disable iff (!arst_n)
		irq_chk |-> irq[soc_pkg::SOC_IRQ_GPIO1] == exp_irq1)
		else begin
			$display("mismatch irq_o[%0d]: got %h expected %h", soc_pkg::SOC_IRQ_GPIO1,
				$sampled(irq[soc_pkg::SOC_IRQ_GPIO1]), $sampled(exp_irq1));
			errors++;
		end

	// Output bits from the data register, input bits from the pads
	function automatic logic [7:0] pad_readback(input logic [7:0] dir, input logic [7:0] dout,
		input logic [7:0] pins);
		logic [7:0] res;
		for (int b = 0; b < 8; b++) begin
			res[b] = dir[b] ? dout[b] : pins[b];
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Host driver
	////////////////////////////////////////////////////////////

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (host_ack !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (host_ack !== level) begin
			$display("timeout: host_ack_o never went to %0d during %s", level, what);
			errors++;
			hung = 1'b1;
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq[soc_pkg::SOC_IRQ_GPIO1] !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (irq[soc_pkg::SOC_IRQ_GPIO1] !== level) begin
			$display("timeout: gpio1 interrupt line never went to %0d", level);
			errors++;
			hung = 1'b1;
		end
	endtask

	// Full four-phase cycle, req held until ack
	task automatic host_xfer(input soc_pkg::soc_cmd_t cmd, input logic check,
		input soc_pkg::soc_rsp_t exp, input string what);
		if (hung) return;
		@(negedge clk);
		host_cmd = cmd;
		rd_chk   = check;
		exp_rsp  = exp;
		host_req = 1'b1;
		wait_ack(1'b1, what);
		host_req = 1'b0;
		if (!hung) wait_ack(1'b0, what);
		rd_chk = 1'b0;
	endtask

	task automatic host_write(input logic [3:0] region, input logic [11:0] offset,
		input logic [31:0] data);
		soc_pkg::soc_cmd_t cmd;
		cmd = '{we: 1'b1, adr: '{region: region, offset: offset}, wdat: data};
		host_xfer(cmd, 1'b0, '0, $sformatf("write to region %h offset %h", region, offset));
	endtask

	task automatic host_read(input logic [3:0] region, input logic [11:0] offset,
		input logic [31:0] exp_dat, input logic exp_err);
		soc_pkg::soc_cmd_t cmd;
		soc_pkg::soc_rsp_t exp;
		cmd = '{we: 1'b0, adr: '{region: region, offset: offset}, wdat: 32'h0};
		exp = '{rdat: exp_dat, err: exp_err};
		host_xfer(cmd, 1'b1, exp, $sformatf("read of region %h offset %h", region, offset));
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - err_mark);
		tests_run++;
		if (errors != err_mark) tests_bad++;
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed      = 32'h4e0ca8ee;
		host_req  = 1'b0;
		host_cmd  = '0;
		gpio0_in  = 8'h00;
		gpio1_in  = 4'h0;
		rd_chk    = 1'b0;
		pad_chk   = 1'b0;
		irq_chk   = 1'b0;
		exp_irq1  = 1'b0;
		exp_rsp   = '0;
		exp_oe    = 8'h00;
		exp_dout  = 8'h00;
		hung      = 1'b0;
		errors    = 0;
		err_mark  = 0;
		tests_run = 0;
		tests_bad = 0;
		arst_n    = 1'b0;
		rst_chk   = 1'b0;
		@(negedge clk);
		rst_chk = 1'b1;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(negedge clk);
		rst_chk = 1'b0;
		end_test("reset_state");

		// Input bits read back from the pads, output bits from the register
		dir_val  = $random(seed);
		wdat     = $random(seed);
		gpio0_in = $random(seed);
		host_write(soc_pkg::SOC_REGION_GPIO0, soc_pkg::SOC_GPIO_DIR, {24'h0, dir_val});
		host_write(soc_pkg::SOC_REGION_GPIO0, soc_pkg::SOC_GPIO_DATA, wdat);
		host_read(soc_pkg::SOC_REGION_GPIO0, soc_pkg::SOC_GPIO_DATA,
			{24'h0, pad_readback(dir_val, wdat[7:0], gpio0_in)}, 1'b0);
		exp_oe   = dir_val;
		exp_dout = wdat[7:0];
		pad_chk  = 1'b1;
		repeat (4) @(negedge clk);
		pad_chk = 1'b0;
		end_test("gpio0_rw");

		for (int k = 0; k < soc_pkg::SOC_ROM_DEPTH; k++) begin
			host_read(soc_pkg::SOC_REGION_ROM, 12'(k), soc_pkg::SOC_ROM_BASE_WORD + 32'(k), 1'b0);
		end
		host_write(soc_pkg::SOC_REGION_ROM, 12'd5, $random(seed));
		host_read(soc_pkg::SOC_REGION_ROM, 12'd5, soc_pkg::SOC_ROM_BASE_WORD + 32'd5, 1'b0);
		end_test("rom_read");

		host_read(4'h3, 12'($random(seed)), soc_pkg::SOC_DEAD_DATA, 1'b1);
		host_read(soc_pkg::SOC_REGION_ROM, 12'd20, soc_pkg::SOC_DEAD_DATA, 1'b1);
		end_test("unmapped");

		// Quiet line first, then a pin change raises it
		pat      = 4'($random(seed)) | 4'h1;
		irq_chk  = 1'b1;
		exp_irq1 = 1'b0;
		repeat (2) @(negedge clk);
		irq_chk  = 1'b0;
		gpio1_in = pat;
		wait_irq(1'b1);
		exp_irq1 = 1'b1;
		irq_chk  = 1'b1;
		host_read(soc_pkg::SOC_REGION_GPIO1, soc_pkg::SOC_GPIO_PEND, {28'h0, pat}, 1'b0);
		irq_chk = 1'b0;
		host_write(soc_pkg::SOC_REGION_GPIO1, soc_pkg::SOC_GPIO_PEND, {28'h0, pat});
		wait_irq(1'b0);
		exp_irq1 = 1'b0;
		irq_chk  = 1'b1;
		repeat (4) @(negedge clk);
		irq_chk = 1'b0;
		end_test("gpio1_irq");

		for (int i = 0; i < 6; i++) begin
			wdat = $random(seed);
			host_write(soc_pkg::SOC_REGION_GPIO0, soc_pkg::SOC_GPIO_DATA, wdat);
		end
		host_read(soc_pkg::SOC_REGION_GPIO0, soc_pkg::SOC_GPIO_DATA,
			{24'h0, pad_readback(dir_val, wdat[7:0], gpio0_in)}, 1'b0);
		end_test("posted_writes");

		$display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* list.f */
src/soc_pkg.sv
src/gpio_port.sv
src/boot_rom.sv
src/cmd_fifo.sv
src/bus_decoder.sv
src/dbg_bridge.sv
src/soc_top.sv
verif/soc_tb.sv
